//--- design/arm_core_params.svh
`ifndef ARM_CORE_PARAMS_SVH
`define ARM_CORE_PARAMS_SVH

// ********************
// Architectural constants
`define ARM_NUM_REGS      16
`define ARM_PC_REG        4'd15
`define ARM_RESET_PC      32'h0000_0000

// Instruction class, bits 27 to 25
`define ARM_CLASS_DP_REG  3'b000
`define ARM_CLASS_DP_IMM  3'b001
`define ARM_CLASS_LDST    3'b010
`define ARM_CLASS_BRANCH  3'b101

// Data processing opcodes, bits 24 to 21
`define ARM_OP_AND        4'b0000
`define ARM_OP_EOR        4'b0001
`define ARM_OP_SUB        4'b0010
`define ARM_OP_ADD        4'b0100
`define ARM_OP_ORR        4'b1100
`define ARM_OP_MOV        4'b1101

// ********************
// Field positions (low bit of each field)
`define ARM_CLASS_LSB     25
`define ARM_OPC_LSB       21
`define ARM_L_BIT         20
`define ARM_RN_LSB        16
`define ARM_RD_LSB        12
`define ARM_RM_LSB        0

`endif

//--- design/arm_core_pkg.sv
package arm_core_pkg;

  typedef logic [31:0] word_t;      // Data or address word
  typedef logic [3:0]  reg_addr_t;  // Register number r0 to r15

  // ********************
  // Decoded instruction class
  typedef enum logic [2:0] {
    CLASS_DP_REG,
    CLASS_DP_IMM,
    CLASS_LDST,
    CLASS_BRANCH,
    CLASS_ILLEGAL
  } inst_class_e;

  typedef enum logic [2:0] {
    ALU_AND,
    ALU_EOR,
    ALU_SUB,
    ALU_ADD,
    ALU_ORR,
    ALU_MOV,
    ALU_PASS_B   // Loads, stores and branches
  } alu_op_e;

  // ********************
  // Pipeline registers
  typedef struct packed {
    logic  valid;
    word_t pc;
    word_t inst;
  } fetch_out_s;

  typedef struct packed {
    logic        valid;
    word_t       pc;
    inst_class_e inst_class;
    alu_op_e     alu_op;
    logic        is_load;
    reg_addr_t   r1_addr;     // Rm, or Rd for loads and stores
    reg_addr_t   r2_addr;     // Rn
    reg_addr_t   rd_addr;
    word_t       r1;
    word_t       r2;
    word_t       imm;
  } decode_out_s;

  typedef struct packed {
    logic      en;
    reg_addr_t addr;
    word_t     data;
  } wb_s;

endpackage

//--- design/register_file.sv
`timescale 1ns/1ps
`include "arm_core_params.svh"

module register_file
  import arm_core_pkg::*;
(
    input  logic      clk_i
  , input  logic      reset_i
  , input  reg_addr_t a_addr_i
  , input  reg_addr_t b_addr_i
  , input  wb_s       wb_i
  , input  word_t     pc_i
  , output word_t     a_o
  , output word_t     b_o
);

  // r15 is not stored, it comes from pc_i
  word_t regs [`ARM_NUM_REGS-1];

  function automatic word_t read_port(reg_addr_t addr);
    word_t value;
    if (addr == `ARM_PC_REG) begin
      value = pc_i + 32'd8;  // ARM pipeline offset
    end else if (wb_i.en && wb_i.addr == addr) begin
      value = wb_i.data;     // Write-through
    end else begin
      value = regs[addr];
    end
    return value;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      for (int i = 0; i < `ARM_NUM_REGS - 1; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_i.en && wb_i.addr != `ARM_PC_REG) begin
      regs[wb_i.addr] <= wb_i.data;
    end
  end

  always_comb begin
    a_o = read_port(a_addr_i);
  end

  always_comb begin
    b_o = read_port(b_addr_i);
  end

  // Execute must never produce a result for the program counter
  a_no_pc_write: assert property (
    @(posedge clk_i) disable iff (reset_i)
    wb_i.en |-> wb_i.addr != `ARM_PC_REG
  ) else $error("register_file: writeback targets r15");

endmodule

//--- design/fetch_stage.sv
`timescale 1ns/1ps
`include "arm_core_params.svh"

module fetch_stage
  import arm_core_pkg::*;
(
    input  logic       clk_i
  , input  logic       reset_i
  , input  logic       stall_i
  , input  logic       flush_i
  , input  word_t      target_i
  , input  word_t      imem_data_i
  , output word_t      imem_addr_o
  , output fetch_out_s fetch_o
);

  word_t pc_q;
  logic  valid_q;
  word_t inst_pc_q;
  word_t inst_q;

  assign imem_addr_o = pc_q;

  // ********************
  // Program counter and valid bit
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_q    <= `ARM_RESET_PC;
      valid_q <= 1'b0;
    end else if (flush_i) begin
      // Redirect wins over stall
      pc_q    <= target_i;
      valid_q <= 1'b0;
    end else if (!stall_i) begin
      pc_q    <= pc_q + 32'd4;
      valid_q <= 1'b1;
    end
  end

  // Instruction word and the address it came from
  always_ff @(posedge clk_i) begin
    if (!stall_i) begin
      inst_pc_q <= pc_q;
      inst_q    <= imem_data_i;
    end
  end

  assign fetch_o = '{
    valid: valid_q,
    pc:    inst_pc_q,
    inst:  inst_q
  };

  // The branch that raised flush is gone from decode one cycle later
  a_flush_is_pulse: assert property (
    @(posedge clk_i) disable iff (reset_i)
    flush_i |=> !flush_i
  ) else $error("fetch_stage: flush held for more than one cycle");

endmodule

//--- design/decode_stage.sv
`timescale 1ns/1ps
`include "arm_core_params.svh"

module decode_stage
  import arm_core_pkg::*;
(
    input  logic        clk_i
  , input  logic        reset_i
  , input  logic        stall_i
  , input  logic        flush_i
  , input  fetch_out_s  fetch_i
  , input  wb_s         wb_i
  , output decode_out_s decode_o
);

  word_t       inst;
  reg_addr_t   rn_addr;
  reg_addr_t   rd_addr;
  reg_addr_t   rm_addr;
  logic [3:0]  opcode;
  logic [2:0]  class_bits;
  reg_addr_t   r1_addr;
  word_t       r1_value;
  word_t       r2_value;
  alu_op_e     dp_op;
  inst_class_e inst_class;
  alu_op_e     alu_op;
  word_t       imm;

  assign inst       = fetch_i.inst;
  assign rn_addr    = inst[`ARM_RN_LSB +: 4];
  assign rd_addr    = inst[`ARM_RD_LSB +: 4];
  assign rm_addr    = inst[`ARM_RM_LSB +: 4];
  assign opcode     = inst[`ARM_OPC_LSB +: 4];
  assign class_bits = inst[`ARM_CLASS_LSB +: 3];

  // ********************
  // Register file reads
  assign r1_addr = (class_bits == `ARM_CLASS_LDST) ? rd_addr : rm_addr;  // Store data is Rd

  register_file u_register_file (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .a_addr_i (r1_addr)
    , .b_addr_i (rn_addr)
    , .wb_i     (wb_i)
    , .pc_i     (fetch_i.pc)
    , .a_o      (r1_value)
    , .b_o      (r2_value)
  );

  // ********************
  // Instruction decode
  always_comb begin
    case (opcode)
      `ARM_OP_AND: dp_op = ALU_AND;
      `ARM_OP_EOR: dp_op = ALU_EOR;
      `ARM_OP_SUB: dp_op = ALU_SUB;
      `ARM_OP_ADD: dp_op = ALU_ADD;
      `ARM_OP_ORR: dp_op = ALU_ORR;
      `ARM_OP_MOV: dp_op = ALU_MOV;
      default:     dp_op = ALU_PASS_B;  // Not in the subset
    endcase
  end

  always_comb begin
    alu_op = ALU_PASS_B;
    imm    = '0;
    case (class_bits)
      `ARM_CLASS_DP_REG: begin
        inst_class = (dp_op == ALU_PASS_B) ? CLASS_ILLEGAL : CLASS_DP_REG;
        alu_op     = dp_op;
      end
      `ARM_CLASS_DP_IMM: begin
        inst_class = (dp_op == ALU_PASS_B) ? CLASS_ILLEGAL : CLASS_DP_IMM;
        alu_op     = dp_op;
        imm        = {24'd0, inst[7:0]};
      end
      `ARM_CLASS_LDST: begin
        inst_class = CLASS_LDST;
        imm        = {20'd0, inst[11:0]};
      end
      `ARM_CLASS_BRANCH: begin
        inst_class = CLASS_BRANCH;
        imm        = {{6{inst[23]}}, inst[23:0], 2'b00};  // Word offset in bytes
      end
      default: inst_class = CLASS_ILLEGAL;
    endcase
  end

  // ********************
  // Decode to execute register
  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      decode_o.valid <= 1'b0;
    end else if (!stall_i) begin
      decode_o.valid <= fetch_i.valid;
    end
    if (!stall_i) begin
      decode_o.pc         <= fetch_i.pc;
      decode_o.inst_class <= inst_class;
      decode_o.alu_op     <= alu_op;
      decode_o.is_load    <= inst[`ARM_L_BIT];
      decode_o.r1_addr    <= r1_addr;
      decode_o.r2_addr    <= rn_addr;
      decode_o.rd_addr    <= rd_addr;
      decode_o.r1         <= r1_value;
      decode_o.r2         <= r2_value;
      decode_o.imm        <= imm;
    end
  end

  a_no_illegal: assert property (
    @(posedge clk_i) disable iff (reset_i)
    decode_o.valid |-> decode_o.inst_class != CLASS_ILLEGAL
  ) else $error("decode_stage: illegal instruction reached execute");

endmodule

//--- design/execute_stage.sv
`timescale 1ns/1ps
`include "arm_core_params.svh"

module execute_stage
  import arm_core_pkg::*;
(
    input  logic        clk_i
  , input  logic        reset_i
  , input  logic        stall_i
  , input  decode_out_s decode_i
  , output logic        flush_o
  , output word_t       target_o
  , output word_t       dmem_addr_o
  , output word_t       dmem_wdata_o
  , output logic        dmem_we_o
  , input  word_t       dmem_rdata_i
  , output wb_s         wb_o
);

  wb_s   wb_q;
  word_t r1_fwd;      // Rm, or Rd for stores
  word_t rn_fwd;
  word_t op_a;
  word_t op_b;
  word_t alu_result;
  logic  is_dp;
  logic  is_ldst;
  logic  is_branch;
  logic  wb_en;
  word_t wb_data;

  // wb_q keeps the last value written to wb_q.addr, even with en low
  function automatic word_t forward(reg_addr_t addr, word_t value);
    word_t result;
    result = value;
    if (addr != `ARM_PC_REG && addr == wb_q.addr) begin
      result = wb_q.data;
    end
    return result;
  endfunction

  // ********************
  // Operands
  always_comb begin
    r1_fwd = forward(decode_i.r1_addr, decode_i.r1);
    rn_fwd = forward(decode_i.r2_addr, decode_i.r2);
  end

  assign is_dp = decode_i.inst_class == CLASS_DP_REG || decode_i.inst_class == CLASS_DP_IMM;
  assign is_ldst   = decode_i.inst_class == CLASS_LDST;
  assign is_branch = decode_i.inst_class == CLASS_BRANCH;

  assign op_a = rn_fwd;
  assign op_b = (decode_i.inst_class == CLASS_DP_IMM) ? decode_i.imm : r1_fwd;

  // ********************
  // ALU
  always_comb begin
    case (decode_i.alu_op)
      ALU_AND: alu_result = op_a & op_b;
      ALU_EOR: alu_result = op_a ^ op_b;
      ALU_SUB: alu_result = op_a - op_b;
      ALU_ADD: alu_result = op_a + op_b;
      ALU_ORR: alu_result = op_a | op_b;
      default: alu_result = op_b;  // MOV and PASS_B
    endcase
  end

  // ********************
  // Data memory and branch
  assign dmem_addr_o  = rn_fwd + decode_i.imm;
  assign dmem_wdata_o = r1_fwd;
  assign dmem_we_o    = decode_i.valid && is_ldst && !decode_i.is_load && !stall_i;

  assign flush_o  = decode_i.valid && is_branch;
  assign target_o = decode_i.pc + 32'd8 + decode_i.imm;

  // ********************
  // Writeback register
  assign wb_en   = decode_i.valid && (is_dp || (is_ldst && decode_i.is_load));
  assign wb_data = is_ldst ? dmem_rdata_i : alu_result;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      wb_q <= '0;  // Matches the cleared register file
    end else if (stall_i) begin
      wb_q.en <= 1'b0;  // A held result is reported once
    end else begin
      wb_q.en <= wb_en;
      if (wb_en) begin
        wb_q.addr <= decode_i.rd_addr;
        wb_q.data <= wb_data;
      end
    end
  end

  assign wb_o = wb_q;

  // The instruction fetched behind a taken branch must never execute
  a_flush_squashes_next: assert property (
    @(posedge clk_i) disable iff (reset_i)
    flush_o |=> !decode_i.valid
  ) else $error("execute_stage: instruction after a taken branch was not squashed");

endmodule

//--- design/arm_core.sv
`timescale 1ns/1ps

module arm_core
  import arm_core_pkg::*;
(
    input  logic      clk_i
  , input  logic      reset_i
  , input  logic      stall_i

  // Instruction memory
  , output word_t     imem_addr_o
  , input  word_t     imem_data_i

  // Data memory
  , output word_t     dmem_addr_o
  , output word_t     dmem_wdata_o
  , output logic      dmem_we_o
  , input  word_t     dmem_rdata_i

  // Writeback trace
  , output logic      wb_en_o
  , output reg_addr_t wb_addr_o
  , output word_t     wb_data_o
);

  fetch_out_s  fetch_w;
  decode_out_s decode_w;
  wb_s         wb_w;
  logic        flush_w;
  word_t       target_w;

  fetch_stage u_fetch_stage (
      .clk_i       (clk_i)
    , .reset_i     (reset_i)
    , .stall_i     (stall_i)
    , .flush_i     (flush_w)
    , .target_i    (target_w)
    , .imem_data_i (imem_data_i)
    , .imem_addr_o (imem_addr_o)
    , .fetch_o     (fetch_w)
  );

  decode_stage u_decode_stage (
      .clk_i    (clk_i)
    , .reset_i  (reset_i)
    , .stall_i  (stall_i)
    , .flush_i  (flush_w)
    , .fetch_i  (fetch_w)
    , .wb_i     (wb_w)
    , .decode_o (decode_w)
  );

  execute_stage u_execute_stage (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .stall_i      (stall_i)
    , .decode_i     (decode_w)
    , .flush_o      (flush_w)
    , .target_o     (target_w)
    , .dmem_addr_o  (dmem_addr_o)
    , .dmem_wdata_o (dmem_wdata_o)
    , .dmem_we_o    (dmem_we_o)
    , .dmem_rdata_i (dmem_rdata_i)
    , .wb_o         (wb_w)
  );

  assign wb_en_o   = wb_w.en;
  assign wb_addr_o = wb_w.addr;
  assign wb_data_o = wb_w.data;

endmodule

//--- test/arm_core_tb.sv
`timescale 1ns/1ps
`include "arm_core_params.svh"

module arm_core_tb
  import arm_core_pkg::*;
();

  localparam int    TIMEOUT_CYCLES = 600;  // Four passes over the program plus stall slack
  localparam int    STALL_AFTER_WB = 8;    // Random stalls start once this many results are seen
  localparam word_t HALT_ADDR      = 32'd120;

  typedef struct packed {
    word_t addr;
    word_t data;
  } store_s;

  logic      clk_i;
  logic      reset_i;
  logic      stall_i;
  word_t     imem_addr_o;
  word_t     imem_data_i;
  word_t     dmem_addr_o;
  word_t     dmem_wdata_o;
  logic      dmem_we_o;
  word_t     dmem_rdata_i;
  logic      wb_en_o;
  reg_addr_t wb_addr_o;
  word_t     wb_data_o;

  word_t  imem [64];
  word_t  dmem [64];
  word_t  model_mem [64];
  word_t  model_regs [16];
  wb_s    exp_wb [$];
  store_s exp_st [$];
  wb_s    wb_head;
  store_s st_head;
  int     cycle_count  = 0;
  int     run_cycle    = 0;   // Rising edges since reset was released
  int     checked_wb   = 0;
  int     halt_fetches = 0;
  logic   stall_phase;

  arm_core u_dut (
      .clk_i        (clk_i)
    , .reset_i      (reset_i)
    , .stall_i      (stall_i)
    , .imem_addr_o  (imem_addr_o)
    , .imem_data_i  (imem_data_i)
    , .dmem_addr_o  (dmem_addr_o)
    , .dmem_wdata_o (dmem_wdata_o)
    , .dmem_we_o    (dmem_we_o)
    , .dmem_rdata_i (dmem_rdata_i)
    , .wb_en_o      (wb_en_o)
    , .wb_addr_o    (wb_addr_o)
    , .wb_data_o    (wb_data_o)
  );

  // Both memories read combinationally
  assign imem_data_i = imem[imem_addr_o[7:2]];
  assign dmem_rdata_i = dmem[dmem_addr_o[7:2]];
  assign stall_phase = checked_wb >= STALL_AFTER_WB;

  // ********************
  // Instruction encoders with the condition field always AL
  function automatic word_t dp_reg(logic [3:0] opc, reg_addr_t rd, reg_addr_t rn, reg_addr_t rm);
    return {4'he, `ARM_CLASS_DP_REG, opc, 1'b0, rn, rd, 8'd0, rm};
  endfunction

  function automatic word_t dp_imm(logic [3:0] opc, reg_addr_t rd, reg_addr_t rn, logic [7:0] imm);
    return {4'he, `ARM_CLASS_DP_IMM, opc, 1'b0, rn, rd, 4'd0, imm};
  endfunction

  function automatic word_t mem_op(logic load, reg_addr_t rd, reg_addr_t rn, logic [11:0] off);
    return {4'he, `ARM_CLASS_LDST, 4'b1100, load, rn, rd, off};  // Pre-indexed with the offset added
  endfunction

  function automatic word_t branch_by(logic [23:0] off);
    return {4'he, `ARM_CLASS_BRANCH, 1'b0, off};
  endfunction

  task automatic load_program();
    for (int i = 0; i < 64; i++) begin
      imem[i] = dp_imm(`ARM_OP_MOV, 4'd0, 4'd0, i[7:0]);
      dmem[i] = 32'hd47a_0000 + word_t'(i * 4);
    end
    imem[0]  = dp_imm(`ARM_OP_MOV, 4'd1, 4'd0, 8'h15);
    imem[1]  = dp_imm(`ARM_OP_MOV, 4'd2, 4'd0, 8'h0c);
    imem[2]  = dp_reg(`ARM_OP_ADD, 4'd3, 4'd1, 4'd2);   // r1 via write-through, r2 forwarded
    imem[3]  = dp_reg(`ARM_OP_SUB, 4'd4, 4'd3, 4'd1);
    imem[4]  = dp_imm(`ARM_OP_AND, 4'd5, 4'd4, 8'h0f);
    imem[5]  = dp_reg(`ARM_OP_ORR, 4'd6, 4'd5, 4'd1);
    imem[6]  = dp_imm(`ARM_OP_EOR, 4'd7, 4'd6, 8'hff);
    imem[7]  = dp_reg(`ARM_OP_MOV, 4'd8, 4'd0, 4'd7);
    imem[8]  = dp_imm(`ARM_OP_ADD, 4'd9, 4'd15, 8'h04);  // Reads r15 as address plus 8
    imem[9]  = dp_reg(`ARM_OP_SUB, 4'd10, 4'd9, 4'd2);
    imem[10] = dp_reg(`ARM_OP_EOR, 4'd11, 4'd10, 4'd3);
    imem[11] = dp_reg(`ARM_OP_AND, 4'd12, 4'd11, 4'd9);
    imem[12] = dp_imm(`ARM_OP_ORR, 4'd13, 4'd12, 8'h80);
    imem[13] = dp_imm(`ARM_OP_MOV, 4'd0, 4'd0, 8'h40);
    imem[14] = mem_op(1'b0, 4'd3, 4'd0, 12'h008);
    imem[15] = mem_op(1'b0, 4'd13, 4'd0, 12'h010);
    imem[16] = mem_op(1'b1, 4'd1, 4'd0, 12'h008);
    imem[17] = dp_reg(`ARM_OP_ADD, 4'd2, 4'd1, 4'd1);   // Load-use
    imem[18] = mem_op(1'b1, 4'd4, 4'd0, 12'h020);
    imem[19] = dp_reg(`ARM_OP_SUB, 4'd5, 4'd4, 4'd2);
    imem[20] = branch_by(24'd2);
    imem[21] = dp_imm(`ARM_OP_MOV, 4'd6, 4'd0, 8'h11);  // These three are skipped
    imem[22] = dp_imm(`ARM_OP_MOV, 4'd7, 4'd0, 8'h22);
    imem[23] = dp_imm(`ARM_OP_MOV, 4'd8, 4'd0, 8'h33);
    imem[24] = dp_reg(`ARM_OP_ADD, 4'd14, 4'd15, 4'd1);
    imem[25] = mem_op(1'b1, 4'd9, 4'd0, 12'h010);
    imem[26] = dp_reg(`ARM_OP_EOR, 4'd10, 4'd9, 4'd14);
    imem[27] = mem_op(1'b0, 4'd10, 4'd15, 12'h000);
    imem[28] = mem_op(1'b1, 4'd11, 4'd0, 12'h034);
    imem[29] = dp_reg(`ARM_OP_MOV, 4'd12, 4'd0, 4'd11);
    imem[30] = branch_by(24'hff_fffe);  // Branch to itself
  endtask

  // ********************
  // Instruction-level reference model
  function automatic word_t model_reg(reg_addr_t r, word_t pc);
    word_t value;
    if (r == 4'd15) begin
      value = pc + 32'd8;
    end else begin
      value = model_regs[r];
    end
    return value;
  endfunction

  task automatic build_expected();
    word_t  pc;
    word_t  inst;
    word_t  op_a;
    word_t  op_b;
    word_t  result;
    word_t  target;
    wb_s    wb_entry;
    store_s st_entry;
    logic   halted;
    int     steps;
    pc         = `ARM_RESET_PC;
    halted     = 1'b0;
    steps      = 0;
    model_regs = '{default: '0};
    model_mem  = dmem;
    while (!halted && steps < 200) begin
      inst  = imem[pc[7:2]];
      op_a  = model_reg(inst[19:16], pc);
      steps = steps + 1;
      case (inst[27:25])
        `ARM_CLASS_DP_REG, `ARM_CLASS_DP_IMM: begin
          op_b = inst[25] ? {24'd0, inst[7:0]} : model_reg(inst[3:0], pc);
          case (inst[24:21])
            `ARM_OP_AND: result = op_a & op_b;
            `ARM_OP_EOR: result = op_a ^ op_b;
            `ARM_OP_SUB: result = op_a - op_b;
            `ARM_OP_ADD: result = op_a + op_b;
            `ARM_OP_ORR: result = op_a | op_b;
            default:     result = op_b;
          endcase
          model_regs[inst[15:12]] = result;
          wb_entry = '{en: 1'b1, addr: inst[15:12], data: result};
          exp_wb.push_back(wb_entry);
          pc = pc + 32'd4;
        end
        `ARM_CLASS_LDST: begin
          st_entry.addr = op_a + {20'd0, inst[11:0]};
          if (inst[20]) begin
            result = model_mem[st_entry.addr[7:2]];
            model_regs[inst[15:12]] = result;
            wb_entry = '{en: 1'b1, addr: inst[15:12], data: result};
            exp_wb.push_back(wb_entry);
          end else begin
            st_entry.data = model_reg(inst[15:12], pc);
            model_mem[st_entry.addr[7:2]] = st_entry.data;
            exp_st.push_back(st_entry);
          end
          pc = pc + 32'd4;
        end
        `ARM_CLASS_BRANCH: begin
          target = pc + 32'd8 + {{6{inst[23]}}, inst[23:0], 2'b00};
          halted = target == pc;
          pc     = target;
        end
        default: halted = 1'b1;
      endcase
    end
  endtask

  // ********************
  // Failure reporting
  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_mismatch(string name, word_t expected, word_t actual);
    abort_run($sformatf("ERROR %s: expected 0x%08h, got 0x%08h", name, expected, actual));
  endtask

  // ********************
  // Clock, stimulus and counters
  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    #1;
    // About one cycle in five, and always when a store first reaches execute
    stall_i = stall_phase && ((($urandom % 100) < 20) || dmem_we_o);
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (!reset_i) begin
      run_cycle <= run_cycle + 1;
    end
    if (!reset_i && !stall_i && imem_addr_o == HALT_ADDR) begin
      halt_fetches <= halt_fetches + 1;
    end
    if (cycle_count >= TIMEOUT_CYCLES) begin
      abort_run("Timeout: the program never reached its halt loop");
    end
  end

  a_no_store_in_stall: assert property (
    @(posedge clk_i) disable iff (reset_i)
    stall_i |-> !dmem_we_o
  ) else abort_run("A store was issued while the pipeline was stalled");

  // Outputs are checked at the falling edge, half a cycle after they settle
  always @(negedge clk_i) begin
    if (reset_i || run_cycle < 3) begin
      a_quiet_start: assert (!wb_en_o && !dmem_we_o)
        else abort_run("Writeback or store strobe active before the first result was due");
    end
    if (run_cycle == 3) begin
      a_first_result: assert (wb_en_o)
        else abort_run("First result did not appear three cycles after its fetch");
    end
    if (!reset_i && wb_en_o) begin
      a_wb_expected: assert (exp_wb.size() > 0)
        else abort_run("A writeback appeared after the last expected result");
      wb_head = exp_wb.pop_front();
      a_wb_addr: assert (wb_addr_o == wb_head.addr)
        else report_mismatch("wb_addr_o", {28'd0, wb_head.addr}, {28'd0, wb_addr_o});
      a_wb_data: assert (wb_data_o == wb_head.data)
        else report_mismatch("wb_data_o", wb_head.data, wb_data_o);
      checked_wb <= checked_wb + 1;
    end
    if (!reset_i && dmem_we_o) begin
      a_st_expected: assert (exp_st.size() > 0)
        else abort_run("A store appeared that the program does not contain");
      st_head = exp_st.pop_front();
      a_st_addr: assert (dmem_addr_o == st_head.addr)
        else report_mismatch("dmem_addr_o", st_head.addr, dmem_addr_o);
      a_st_data: assert (dmem_wdata_o == st_head.data)
        else report_mismatch("dmem_wdata_o", st_head.data, dmem_wdata_o);
    end
  end

  // Data memory write port
  always @(posedge clk_i) begin
    if (dmem_we_o) begin
      dmem[dmem_addr_o[7:2]] = dmem_wdata_o;
    end
  end

  initial begin
    void'($urandom(32'h68c4));
    reset_i = 1'b1;
    stall_i = 1'b0;
    load_program();
    build_expected();
    repeat (4) @(posedge clk_i);
    #1 reset_i = 1'b0;
    // Several passes through the halt loop mean every older instruction has retired
    while (halt_fetches < 4) begin
      @(posedge clk_i);
    end
    #10;
    if (exp_wb.size() == 0 && exp_st.size() == 0) begin
      $display("*** TEST PASSED ***");
      $finish;
    end else begin
      abort_run($sformatf("Halted with %0d results and %0d stores never seen",
                          exp_wb.size(), exp_st.size()));
    end
  end

endmodule

//--- compile.f
+incdir+design
design/arm_core_pkg.sv
design/register_file.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/arm_core.sv
test/arm_core_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the arm_core testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  -f compile.f --top-module arm_core_tb -o arm_core_tb

# $fatal gives a nonzero exit, so the log decides the result
./obj_dir/arm_core_tb > sim.log 2>&1 || true
cat sim.log

if grep -qF "*** TEST FAILED ***" sim.log || ! grep -qF "*** TEST PASSED ***" sim.log; then
  echo "Simulation failed, see sim.log"
  exit 1
fi
echo "Simulation passed"
